// File: bilin_fix_pkg.sv
package bilin_fix_pkg;

  // ------------------------------------------------------------------
  // Pixel and dimension formats
  // ------------------------------------------------------------------

  // Grey pixel
  localparam int PIX_W = 8;

  // Image sizes and output coordinates
  localparam int DIM_W = 16;

  // ------------------------------------------------------------------
  // Fixed-point formats
  // ------------------------------------------------------------------

  // Fraction bits of the Q8.8 scale and source coordinates
  localparam int FRAC_W = 8;

  // 1.0 as a Q0.8 weight, one bit wider than the fraction
  localparam logic [8:0] ONE_Q08 = 9'd256;

  // Half an LSB of the Q16.16 weighted sum
  localparam logic [31:0] ROUND_Q016 = 32'h0000_8000;

  // 1.0 in Q16.16, divided by the Q8.8 scale to get a Q8.8 inverse
  localparam logic [31:0] INV_NUM = 32'd65536;

  // Weighted sum of four neighbours
  localparam int SUM_W = 32;

  // Fraction used when a coordinate is clamped at an edge
  localparam logic [7:0] FRAC_MAX = 8'hFF;

endpackage

// File: bilin_seq_pkg.sv
package bilin_seq_pkg;

  // ------------------------------------------------------------------
  // Source memory layout
  // ------------------------------------------------------------------

  // One word holds four pixels, pixel 0 in the low byte
  localparam int WORD_W       = 32;
  localparam int PIX_PER_WORD = 4;

  // Row pitch is fixed by the widest supported source image
  localparam int IMG_W_MAX     = 64;
  localparam int WORDS_PER_ROW = IMG_W_MAX / PIX_PER_WORD;

  // Source word address and output pixel address
  localparam int AW = 18;

  // ------------------------------------------------------------------
  // Sequencing
  // ------------------------------------------------------------------

  // Neighbour fetch, row 0 then row 1, each with an optional next word
  typedef enum logic [3:0] {
    F_IDLE,
    F_R0_REQ,
    F_R0_WAIT,
    F_R0N_REQ,
    F_R0N_WAIT,
    F_R1_REQ,
    F_R1_WAIT,
    F_R1N_REQ,
    F_R1N_WAIT
  } fetch_state_t;

  // Top level run sequence
  typedef enum logic [2:0] {
    C_IDLE,
    C_LOAD,
    C_PIXEL,
    C_FETCH,
    C_WRITE,
    C_DONE
  } ctrl_state_t;

endpackage

// File: bilin_scale_setup.sv
`timescale 1ns/100ps

module bilin_scale_setup (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            i_load,
  input  logic [bilin_fix_pkg::DIM_W-1:0] i_in_w,
  input  logic [bilin_fix_pkg::DIM_W-1:0] i_in_h,
  input  logic [bilin_fix_pkg::DIM_W-1:0] i_scale_q88,
  output logic [bilin_fix_pkg::DIM_W-1:0] o_out_w,
  output logic [bilin_fix_pkg::DIM_W-1:0] o_out_h,
  output logic [bilin_fix_pkg::DIM_W-1:0] o_inv_scale
);

  // Size times Q8.8 scale, integer part sits above the fraction bits
  logic [31:0] mul_w;
  logic [31:0] mul_h;
  // 1.0 / scale, result is Q8.8
  logic [31:0] inv_full;

  assign mul_w    = i_in_w * i_scale_q88;
  assign mul_h    = i_in_h * i_scale_q88;
  assign inv_full = bilin_fix_pkg::INV_NUM / i_scale_q88;

  // Captured once per run, held until the next load
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_out_w     <= '0;
      o_out_h     <= '0;
      o_inv_scale <= '0;
    end else if (i_load) begin
      o_out_w     <= mul_w[bilin_fix_pkg::DIM_W+bilin_fix_pkg::FRAC_W-1:bilin_fix_pkg::FRAC_W];
      o_out_h     <= mul_h[bilin_fix_pkg::DIM_W+bilin_fix_pkg::FRAC_W-1:bilin_fix_pkg::FRAC_W];
      o_inv_scale <= inv_full[bilin_fix_pkg::DIM_W-1:0];
    end
  end

  // Zero scale has no inverse
  a_scale_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
    i_load |-> (i_scale_q88 != '0))
    else $error("scale_setup: zero scale at load");

endmodule

// File: bilin_coord_gen.sv
`timescale 1ns/100ps

module bilin_coord_gen (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             i_first,
  input  logic                             i_next,
  input  logic [bilin_fix_pkg::DIM_W-1:0]  i_in_w,
  input  logic [bilin_fix_pkg::DIM_W-1:0]  i_in_h,
  input  logic [bilin_fix_pkg::DIM_W-1:0]  i_out_w,
  input  logic [bilin_fix_pkg::DIM_W-1:0]  i_out_h,
  input  logic [bilin_fix_pkg::DIM_W-1:0]  i_inv_scale,
  output logic [bilin_fix_pkg::DIM_W-1:0]  o_xi,
  output logic [bilin_fix_pkg::DIM_W-1:0]  o_yi,
  output logic [bilin_fix_pkg::FRAC_W-1:0] o_fx,
  output logic [bilin_fix_pkg::FRAC_W-1:0] o_fy,
  output logic [bilin_seq_pkg::AW-1:0]     o_out_addr,
  output logic                             o_last
);

  // Output raster position, current and next
  logic [bilin_fix_pkg::DIM_W-1:0] ox;
  logic [bilin_fix_pkg::DIM_W-1:0] oy;
  logic [bilin_fix_pkg::DIM_W-1:0] ox_nxt;
  logic [bilin_fix_pkg::DIM_W-1:0] oy_nxt;
  logic [bilin_seq_pkg::AW-1:0]    addr_nxt;
  // Source coordinates in Q16.8 before clamping
  logic [31:0] sx;
  logic [31:0] sy;

  // Split one axis into {base, fraction}, keeping base+1 inside the image
  function automatic logic [bilin_fix_pkg::DIM_W+bilin_fix_pkg::FRAC_W-1:0] clamp_axis(
    input logic [31:0]                     s,
    input logic [bilin_fix_pkg::DIM_W-1:0] size
  );
    logic [bilin_fix_pkg::DIM_W-1:0]  base;
    logic [bilin_fix_pkg::FRAC_W-1:0] frac;
    base = s[bilin_fix_pkg::DIM_W+bilin_fix_pkg::FRAC_W-1:bilin_fix_pkg::FRAC_W];
    frac = s[bilin_fix_pkg::FRAC_W-1:0];
    // At or past the last column/row, sit on the last pair
    if (base >= size - 16'd1) begin
      base = size - 16'd2;
      frac = bilin_fix_pkg::FRAC_MAX;
    end
    return {base, frac};
  endfunction

  // ------------------------------------------------------------------
  // Raster step
  // ------------------------------------------------------------------
  always_comb begin
    ox_nxt   = ox;
    oy_nxt   = oy;
    addr_nxt = o_out_addr;
    if (i_first) begin
      ox_nxt   = '0;
      oy_nxt   = '0;
      addr_nxt = '0;
    end else if (i_next) begin
      addr_nxt = o_out_addr + 1'b1;
      // Wrap at the end of an output row
      if (ox + 16'd1 >= i_out_w) begin
        ox_nxt = '0;
        oy_nxt = oy + 16'd1;
      end else begin
        ox_nxt = ox + 16'd1;
      end
    end
  end

  // Map the new output position back into the source
  assign sx = ox_nxt * i_inv_scale;
  assign sy = oy_nxt * i_inv_scale;

  // ------------------------------------------------------------------
  // Registered coordinates, valid the cycle after a step
  // ------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ox         <= '0;
      oy         <= '0;
      o_out_addr <= '0;
      o_xi       <= '0;
      o_yi       <= '0;
      o_fx       <= '0;
      o_fy       <= '0;
      o_last     <= 1'b0;
    end else if (i_first || i_next) begin
      ox           <= ox_nxt;
      oy           <= oy_nxt;
      o_out_addr   <= addr_nxt;
      {o_xi, o_fx} <= clamp_axis(sx, i_in_w);
      {o_yi, o_fy} <= clamp_axis(sy, i_in_h);
      o_last       <= (ox_nxt == i_out_w - 16'd1) && (oy_nxt == i_out_h - 16'd1);
    end
  end

  // Base pair never runs off the right or bottom edge
  a_base_in_range: assert property (@(posedge clk) disable iff (!rst_n)
    (i_first || i_next) |=> (o_xi <= i_in_w - 16'd2) && (o_yi <= i_in_h - 16'd2))
    else $error("coord_gen: base coordinate outside source image");

endmodule

// File: bilin_neighbor_fetch.sv
`timescale 1ns/100ps

module bilin_neighbor_fetch (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              i_fetch,
  input  logic [bilin_fix_pkg::DIM_W-1:0]   i_xi,
  input  logic [bilin_fix_pkg::DIM_W-1:0]   i_yi,
  input  logic                              i_req_ready,
  input  logic                              i_resp_valid,
  input  logic [bilin_seq_pkg::WORD_W-1:0]  i_resp_rdata,
  output logic                              o_req_valid,
  output logic [bilin_seq_pkg::AW-1:0]      o_req_addr,
  output logic                              o_ready_pix,
  output logic [bilin_fix_pkg::PIX_W-1:0]   o_i00,
  output logic [bilin_fix_pkg::PIX_W-1:0]   o_i10,
  output logic [bilin_fix_pkg::PIX_W-1:0]   o_i01,
  output logic [bilin_fix_pkg::PIX_W-1:0]   o_i11
);

  bilin_seq_pkg::fetch_state_t state;
  bilin_seq_pkg::fetch_state_t state_nxt;

  // Word addresses of the base word in both rows
  logic [31:0]                    lin_r0;
  logic [31:0]                    lin_r1;
  logic [bilin_seq_pkg::AW-1:0]   addr_r0;
  logic [bilin_seq_pkg::AW-1:0]   addr_r1;
  // Base pixel position inside its word
  logic [1:0]                     pix_off;
  // Right neighbour lives in the following word
  logic                           need_nxt;
  // Last response of this pixel arrives now
  logic                           fetch_end;
  // Captured words, next word in the upper half
  logic [bilin_seq_pkg::WORD_W-1:0]   row0_w;
  logic [bilin_seq_pkg::WORD_W-1:0]   row0_nw;
  logic [bilin_seq_pkg::WORD_W-1:0]   row1_w;
  logic [bilin_seq_pkg::WORD_W-1:0]   row1_nw;
  logic [2*bilin_seq_pkg::WORD_W-1:0] row0_pair;
  logic [2*bilin_seq_pkg::WORD_W-1:0] row1_pair;

  assign pix_off  = i_xi[1:0];
  assign need_nxt = (pix_off == 2'd3);
  assign lin_r0   = i_yi * bilin_seq_pkg::WORDS_PER_ROW + i_xi[bilin_fix_pkg::DIM_W-1:2];
  assign lin_r1   = (i_yi + 16'd1) * bilin_seq_pkg::WORDS_PER_ROW
                  + i_xi[bilin_fix_pkg::DIM_W-1:2];
  assign addr_r0  = lin_r0[bilin_seq_pkg::AW-1:0];
  assign addr_r1  = lin_r1[bilin_seq_pkg::AW-1:0];

  // ------------------------------------------------------------------
  // Request side, held by state so it stays put until accepted
  // ------------------------------------------------------------------
  assign o_req_valid = (state == bilin_seq_pkg::F_R0_REQ)  ||
                       (state == bilin_seq_pkg::F_R0N_REQ) ||
                       (state == bilin_seq_pkg::F_R1_REQ)  ||
                       (state == bilin_seq_pkg::F_R1N_REQ);

  always_comb begin
    case (state)
      bilin_seq_pkg::F_R0_REQ:  o_req_addr = addr_r0;
      bilin_seq_pkg::F_R0N_REQ: o_req_addr = addr_r0 + 1'b1;
      bilin_seq_pkg::F_R1_REQ:  o_req_addr = addr_r1;
      default:                  o_req_addr = addr_r1 + 1'b1;
    endcase
  end

  // ------------------------------------------------------------------
  // Fetch sequence
  // ------------------------------------------------------------------
  always_comb begin
    state_nxt = state;
    fetch_end = 1'b0;
    case (state)
      bilin_seq_pkg::F_IDLE:
        if (i_fetch) state_nxt = bilin_seq_pkg::F_R0_REQ;
      bilin_seq_pkg::F_R0_REQ:
        if (i_req_ready) state_nxt = bilin_seq_pkg::F_R0_WAIT;
      bilin_seq_pkg::F_R0_WAIT:
        if (i_resp_valid) begin
          state_nxt = need_nxt ? bilin_seq_pkg::F_R0N_REQ : bilin_seq_pkg::F_R1_REQ;
        end
      bilin_seq_pkg::F_R0N_REQ:
        if (i_req_ready) state_nxt = bilin_seq_pkg::F_R0N_WAIT;
      bilin_seq_pkg::F_R0N_WAIT:
        if (i_resp_valid) state_nxt = bilin_seq_pkg::F_R1_REQ;
      bilin_seq_pkg::F_R1_REQ:
        if (i_req_ready) state_nxt = bilin_seq_pkg::F_R1_WAIT;
      bilin_seq_pkg::F_R1_WAIT:
        if (i_resp_valid) begin
          state_nxt = need_nxt ? bilin_seq_pkg::F_R1N_REQ : bilin_seq_pkg::F_IDLE;
          fetch_end = !need_nxt;
        end
      bilin_seq_pkg::F_R1N_REQ:
        if (i_req_ready) state_nxt = bilin_seq_pkg::F_R1N_WAIT;
      bilin_seq_pkg::F_R1N_WAIT:
        if (i_resp_valid) begin
          state_nxt = bilin_seq_pkg::F_IDLE;
          fetch_end = 1'b1;
        end
      default: state_nxt = bilin_seq_pkg::F_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state       <= bilin_seq_pkg::F_IDLE;
      o_ready_pix <= 1'b0;
    end else begin
      state       <= state_nxt;
      o_ready_pix <= fetch_end;
    end
  end

  // Response capture by wait state
  always_ff @(posedge clk) begin
    if (i_resp_valid) begin
      case (state)
        bilin_seq_pkg::F_R0_WAIT:  row0_w  <= i_resp_rdata;
        bilin_seq_pkg::F_R0N_WAIT: row0_nw <= i_resp_rdata;
        bilin_seq_pkg::F_R1_WAIT:  row1_w  <= i_resp_rdata;
        bilin_seq_pkg::F_R1N_WAIT: row1_nw <= i_resp_rdata;
        default: ;
      endcase
    end
  end

  // ------------------------------------------------------------------
  // Neighbour select, offset 3 reaches into the next word
  // ------------------------------------------------------------------
  assign row0_pair = {row0_nw, row0_w};
  assign row1_pair = {row1_nw, row1_w};
  assign o_i00 = row0_pair[pix_off*bilin_fix_pkg::PIX_W +: bilin_fix_pkg::PIX_W];
  assign o_i10 = row0_pair[(pix_off+1)*bilin_fix_pkg::PIX_W +: bilin_fix_pkg::PIX_W];
  assign o_i01 = row1_pair[pix_off*bilin_fix_pkg::PIX_W +: bilin_fix_pkg::PIX_W];
  assign o_i11 = row1_pair[(pix_off+1)*bilin_fix_pkg::PIX_W +: bilin_fix_pkg::PIX_W];

  // Coordinates from coord_gen must hold while a request is stalled
  a_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (o_req_valid && !i_req_ready) |=> (o_req_valid && $stable(o_req_addr)))
    else $error("neighbor_fetch: request address changed while waiting");

endmodule

// File: bilin_interp.sv
`timescale 1ns/100ps

module bilin_interp (
  input  logic [bilin_fix_pkg::PIX_W-1:0]  i_i00,
  input  logic [bilin_fix_pkg::PIX_W-1:0]  i_i10,
  input  logic [bilin_fix_pkg::PIX_W-1:0]  i_i01,
  input  logic [bilin_fix_pkg::PIX_W-1:0]  i_i11,
  input  logic [bilin_fix_pkg::FRAC_W-1:0] i_fx,
  input  logic [bilin_fix_pkg::FRAC_W-1:0] i_fy,
  output logic [bilin_fix_pkg::PIX_W-1:0]  o_pix
);

  // Q0.8 axis weights, 256 possible so one extra bit
  logic [8:0]  wx0;
  logic [8:0]  wx1;
  logic [8:0]  wy0;
  logic [8:0]  wy1;
  // Q0.16 corner weights
  logic [17:0] w00;
  logic [17:0] w10;
  logic [17:0] w01;
  logic [17:0] w11;
  // Weighted sum in Q16.16, then rounded
  logic [bilin_fix_pkg::SUM_W-1:0] sum_all;
  logic [bilin_fix_pkg::SUM_W-1:0] sum_rnd;

  always_comb begin
    wx1 = {1'b0, i_fx};
    wy1 = {1'b0, i_fy};
    wx0 = bilin_fix_pkg::ONE_Q08 - wx1;
    wy0 = bilin_fix_pkg::ONE_Q08 - wy1;
    // Corner weights sum to 1.0
    w00 = wx0 * wy0;
    w10 = wx1 * wy0;
    w01 = wx0 * wy1;
    w11 = wx1 * wy1;
    sum_all = w00 * i_i00 + w10 * i_i10 + w01 * i_i01 + w11 * i_i11;
    sum_rnd = sum_all + bilin_fix_pkg::ROUND_Q016;
  end

  // Integer byte of the rounded sum
  assign o_pix = sum_rnd[23:16];

endmodule

// File: bilin_scaler_top.sv
`timescale 1ns/100ps

module bilin_scaler_top (
  input  logic                             clk,
  input  logic                             rst_n,
  // Run control
  input  logic                             i_start,
  input  logic [bilin_fix_pkg::DIM_W-1:0]  i_in_w,
  input  logic [bilin_fix_pkg::DIM_W-1:0]  i_in_h,
  input  logic [bilin_fix_pkg::DIM_W-1:0]  i_scale_q88,
  output logic                             o_busy,
  output logic                             o_done,
  output logic [bilin_fix_pkg::DIM_W-1:0]  o_out_w,
  output logic [bilin_fix_pkg::DIM_W-1:0]  o_out_h,
  // Source read bus
  output logic                             o_req_valid,
  output logic [bilin_seq_pkg::AW-1:0]     o_req_addr,
  input  logic                             i_req_ready,
  input  logic                             i_resp_valid,
  input  logic [bilin_seq_pkg::WORD_W-1:0] i_resp_rdata,
  // Output pixel write port
  output logic                             o_out_we,
  output logic [bilin_seq_pkg::AW-1:0]     o_out_waddr,
  output logic [bilin_fix_pkg::PIX_W-1:0]  o_out_wdata
);

  bilin_seq_pkg::ctrl_state_t state;
  bilin_seq_pkg::ctrl_state_t state_nxt;

  // Block handshakes
  logic load;
  logic step_first;
  logic step_next;
  logic fetch;
  logic ready_pix;
  logic last;

  logic [bilin_fix_pkg::DIM_W-1:0]  inv_scale;
  logic [bilin_fix_pkg::DIM_W-1:0]  xi;
  logic [bilin_fix_pkg::DIM_W-1:0]  yi;
  logic [bilin_fix_pkg::FRAC_W-1:0] fx;
  logic [bilin_fix_pkg::FRAC_W-1:0] fy;
  logic [bilin_seq_pkg::AW-1:0]     out_addr;
  logic [bilin_fix_pkg::PIX_W-1:0]  i00;
  logic [bilin_fix_pkg::PIX_W-1:0]  i10;
  logic [bilin_fix_pkg::PIX_W-1:0]  i01;
  logic [bilin_fix_pkg::PIX_W-1:0]  i11;
  logic [bilin_fix_pkg::PIX_W-1:0]  pix;

  // ------------------------------------------------------------------
  // Control sequence
  // ------------------------------------------------------------------
  assign load       = (state == bilin_seq_pkg::C_IDLE) && i_start;
  assign step_first = (state == bilin_seq_pkg::C_LOAD);
  assign fetch      = (state == bilin_seq_pkg::C_PIXEL);
  assign step_next  = (state == bilin_seq_pkg::C_WRITE) && !last;

  always_comb begin
    state_nxt = state;
    case (state)
      bilin_seq_pkg::C_IDLE:  if (i_start) state_nxt = bilin_seq_pkg::C_LOAD;
      bilin_seq_pkg::C_LOAD:  state_nxt = bilin_seq_pkg::C_PIXEL;
      bilin_seq_pkg::C_PIXEL: state_nxt = bilin_seq_pkg::C_FETCH;
      bilin_seq_pkg::C_FETCH: if (ready_pix) state_nxt = bilin_seq_pkg::C_WRITE;
      // Back for the next pixel unless this one closed the frame
      bilin_seq_pkg::C_WRITE: state_nxt = last ? bilin_seq_pkg::C_DONE
                                               : bilin_seq_pkg::C_PIXEL;
      default:                state_nxt = bilin_seq_pkg::C_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= bilin_seq_pkg::C_IDLE;
      o_busy   <= 1'b0;
      o_done   <= 1'b0;
      o_out_we <= 1'b0;
    end else begin
      state    <= state_nxt;
      o_done   <= (state == bilin_seq_pkg::C_DONE);
      o_out_we <= (state == bilin_seq_pkg::C_WRITE);
      if (load) begin
        o_busy <= 1'b1;
      end else if (state == bilin_seq_pkg::C_DONE) begin
        o_busy <= 1'b0;
      end
    end
  end

  // Write payload, coordinates still belong to the current pixel here
  always_ff @(posedge clk) begin
    if (state == bilin_seq_pkg::C_WRITE) begin
      o_out_waddr <= out_addr;
      o_out_wdata <= pix;
    end
  end

  // ------------------------------------------------------------------
  // Datapath blocks
  // ------------------------------------------------------------------
  bilin_scale_setup u_setup (
    .clk(clk), .rst_n(rst_n), .i_load(load),
    .i_in_w(i_in_w), .i_in_h(i_in_h), .i_scale_q88(i_scale_q88),
    .o_out_w(o_out_w), .o_out_h(o_out_h), .o_inv_scale(inv_scale)
  );

  bilin_coord_gen u_coord (
    .clk(clk), .rst_n(rst_n), .i_first(step_first), .i_next(step_next),
    .i_in_w(i_in_w), .i_in_h(i_in_h), .i_out_w(o_out_w), .i_out_h(o_out_h),
    .i_inv_scale(inv_scale),
    .o_xi(xi), .o_yi(yi), .o_fx(fx), .o_fy(fy),
    .o_out_addr(out_addr), .o_last(last)
  );

  bilin_neighbor_fetch u_fetch (
    .clk(clk), .rst_n(rst_n), .i_fetch(fetch), .i_xi(xi), .i_yi(yi),
    .i_req_ready(i_req_ready), .i_resp_valid(i_resp_valid), .i_resp_rdata(i_resp_rdata),
    .o_req_valid(o_req_valid), .o_req_addr(o_req_addr), .o_ready_pix(ready_pix),
    .o_i00(i00), .o_i10(i10), .o_i01(i01), .o_i11(i11)
  );

  bilin_interp u_interp (
    .i_i00(i00), .i_i10(i10), .i_i01(i01), .i_i11(i11),
    .i_fx(fx), .i_fy(fy), .o_pix(pix)
  );

  // Writes only happen inside a run
  a_we_in_busy: assert property (@(posedge clk) disable iff (!rst_n)
    o_out_we |-> o_busy)
    else $error("scaler_top: write outside busy");

  // Interpolation needs a 2x2 neighbourhood
  a_min_size: assert property (@(posedge clk) disable iff (!rst_n)
    load |-> (i_in_w >= 16'd2) && (i_in_h >= 16'd2))
    else $error("scaler_top: source image smaller than 2x2");

endmodule

// File: bilin_scaler_tb.sv
`timescale 1ns/100ps

module bilin_scaler_tb;

  // Source memory covers 64 rows at the fixed pitch
  localparam int MEM_ROWS  = 64;
  localparam int MEM_WORDS = MEM_ROWS * bilin_seq_pkg::WORDS_PER_ROW;

  logic                             clk;
  logic                             rst_n;
  logic                             i_start;
  logic [15:0]                      i_in_w;
  logic [15:0]                      i_in_h;
  logic [15:0]                      i_scale_q88;
  logic                             o_busy;
  logic                             o_done;
  logic [15:0]                      o_out_w;
  logic [15:0]                      o_out_h;
  logic                             o_req_valid;
  logic [bilin_seq_pkg::AW-1:0]     o_req_addr;
  logic                             i_req_ready;
  logic                             i_resp_valid;
  logic [31:0]                      i_resp_rdata;
  logic                             o_out_we;
  logic [bilin_seq_pkg::AW-1:0]     o_out_waddr;
  logic [bilin_fix_pkg::PIX_W-1:0]  o_out_wdata;

  logic [31:0] src_mem [0:MEM_WORDS-1];
  integer      seed = 9;
  int          wd_cycles = 0;
  // Size of the run in flight for the read address check
  int          cur_in_w;
  int          cur_in_h;
  // One entry per data file line
  int          q_in_w[$];
  int          q_in_h[$];
  int          q_scale[$];
  int          q_out_w[$];
  int          q_out_h[$];

  bilin_scaler_top UUT (
    .clk(clk), .rst_n(rst_n),
    .i_start(i_start), .i_in_w(i_in_w), .i_in_h(i_in_h), .i_scale_q88(i_scale_q88),
    .o_busy(o_busy), .o_done(o_done), .o_out_w(o_out_w), .o_out_h(o_out_h),
    .o_req_valid(o_req_valid), .o_req_addr(o_req_addr), .i_req_ready(i_req_ready),
    .i_resp_valid(i_resp_valid), .i_resp_rdata(i_resp_rdata),
    .o_out_we(o_out_we), .o_out_waddr(o_out_waddr), .o_out_wdata(o_out_wdata)
  );

  // 4 ns clock
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ------------------------------------------------------------------
  // Failure reporting and reference model
  // ------------------------------------------------------------------
  task automatic stop_with_failure();
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s, got %0d, expected %0d", $time, what, got, exp);
      stop_with_failure();
    end
  endtask

  // Grey ramp in both directions
  function automatic int source_pixel(input int x, input int y);
    return (x * 7 + y * 13) % 256;
  endfunction

  function automatic int expect_pixel(input int ox, input int oy, input int in_w,
                                      input int in_h, input int inv);
    int sx;
    int sy;
    int xb;
    int yb;
    int fx;
    int fy;
    int sum;
    sx = ox * inv;
    sy = oy * inv;
    xb = (sx >> 8) & 16'hFFFF;
    yb = (sy >> 8) & 16'hFFFF;
    fx = sx & 8'hFF;
    fy = sy & 8'hFF;
    // Right and bottom edge sit on the last neighbour pair
    if (xb >= in_w - 1) begin
      xb = in_w - 2;
      fx = 255;
    end
    if (yb >= in_h - 1) begin
      yb = in_h - 2;
      fy = 255;
    end
    sum = (256 - fx) * (256 - fy) * source_pixel(xb, yb)
        + fx * (256 - fy) * source_pixel(xb + 1, yb)
        + (256 - fx) * fy * source_pixel(xb, yb + 1)
        + fx * fy * source_pixel(xb + 1, yb + 1);
    // Round half up and keep the integer byte
    return ((sum + 32'h8000) >> 16) & 8'hFF;
  endfunction

  // ------------------------------------------------------------------
  // One scaler run with all write and done checks
  // ------------------------------------------------------------------
  task automatic run_scale(input int t);
    int in_w;
    int in_h;
    int scale;
    int exp_w;
    int exp_h;
    int inv;
    int total;
    int n;
    int ox;
    int oy;
    bit done_seen;
    bit we_prev;
    in_w  = q_in_w[t];
    in_h  = q_in_h[t];
    scale = q_scale[t];
    exp_w = q_out_w[t];
    exp_h = q_out_h[t];
    inv   = (65536 / scale) & 16'hFFFF;
    total = exp_w * exp_h;
    // Data file must agree with the size rule
    check_eq(((in_w * scale) >> 8) & 16'hFFFF, exp_w, $sformatf("test %0d out_w rule", t));
    check_eq(((in_h * scale) >> 8) & 16'hFFFF, exp_h, $sformatf("test %0d out_h rule", t));
    cur_in_w = in_w;
    cur_in_h = in_h;
    @(posedge clk);
    #1;
    i_in_w      = in_w;
    i_in_h      = in_h;
    i_scale_q88 = scale;
    i_start     = 1'b1;
    @(negedge clk);
    check_eq(o_busy, 1'b0, "busy before start is taken");
    @(posedge clk);
    #1;
    i_start   = 1'b0;
    n         = 0;
    done_seen = 1'b0;
    we_prev   = 1'b0;
    @(negedge clk);
    check_eq(o_out_w, exp_w, $sformatf("test %0d o_out_w", t));
    check_eq(o_out_h, exp_h, $sformatf("test %0d o_out_h", t));
    while (!done_seen) begin
      if (o_out_we) begin
        check_eq(n < total, 1'b1, "more writes than out_w*out_h");
        check_eq(o_busy, 1'b1, "write outside busy");
        ox = n % exp_w;
        oy = n / exp_w;
        check_eq(o_out_waddr, oy * exp_w + ox, $sformatf("address of pixel (%0d,%0d)", ox, oy));
        check_eq(o_out_wdata, expect_pixel(ox, oy, in_w, in_h, inv),
                 $sformatf("test %0d pixel (%0d,%0d)", t, ox, oy));
        n++;
      end
      if (o_done) begin
        check_eq(o_busy, 1'b0, "busy falls with done");
        check_eq(n, total, $sformatf("test %0d write count", t));
        check_eq(we_prev, 1'b1, "done right after the last write");
        done_seen = 1'b1;
      end else begin
        check_eq(o_busy, 1'b1, "busy held until done");
      end
      we_prev = o_out_we;
      @(negedge clk);
    end
    // Done is a single pulse
    check_eq(o_done, 1'b0, "done pulse longer than one cycle");
    check_eq(o_busy, 1'b0, "busy after done");
  endtask

  // ------------------------------------------------------------------
  // Source memory on the read bus with random stalls and latency
  // ------------------------------------------------------------------
  initial begin : memory_model
    logic [bilin_seq_pkg::AW-1:0] req_addr;
    bit accepted;
    int lat;
    i_req_ready  = 1'b0;
    i_resp_valid = 1'b0;
    i_resp_rdata = '0;
    forever begin
      // Mid-cycle view of the handshake taken at the next edge
      @(negedge clk);
      accepted = o_req_valid && i_req_ready;
      req_addr = o_req_addr;
      @(posedge clk);
      #1;
      if (accepted) begin
        check_eq(req_addr / bilin_seq_pkg::WORDS_PER_ROW < cur_in_h, 1'b1,
                 $sformatf("read address %0d below the image", req_addr));
        check_eq(req_addr % bilin_seq_pkg::WORDS_PER_ROW <= (cur_in_w - 1) / 4, 1'b1,
                 $sformatf("read address %0d right of the image", req_addr));
        i_req_ready = 1'b0;
        lat = $random(seed) & 3;
        repeat (lat) begin
          @(posedge clk);
          #1;
        end
        i_resp_valid = 1'b1;
        i_resp_rdata = src_mem[req_addr];
        @(posedge clk);
        #1;
        i_resp_valid = 1'b0;
      end
      // Ready about three cycles in four
      i_req_ready = ($random(seed) & 3) != 0;
    end
  end

  // Watchdog armed once the test lengths are known
  initial begin : watchdog
    wait (wd_cycles != 0);
    repeat (wd_cycles) @(posedge clk);
    $display("Timeout: the run did not finish within %0d clock cycles", wd_cycles);
    stop_with_failure();
  end

  // ------------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------------
  initial begin : main_flow
    int fd;
    int rc;
    int a;
    int b;
    int c;
    int d;
    int e;
    int cycles;
    logic [8*120-1:0] line;
    logic [31:0] word;
    rst_n       = 1'b0;
    i_start     = 1'b0;
    i_in_w      = '0;
    i_in_h      = '0;
    i_scale_q88 = '0;
    cur_in_w    = 0;
    cur_in_h    = 0;
    // Four pixels per word with pixel 0 in the low byte
    for (int w = 0; w < MEM_WORDS; w++) begin
      word = '0;
      for (int k = 0; k < 4; k++) begin
        word = word | (source_pixel((w % bilin_seq_pkg::WORDS_PER_ROW) * 4 + k,
                                    w / bilin_seq_pkg::WORDS_PER_ROW)
                       << (k * bilin_fix_pkg::PIX_W));
      end
      src_mem[w] = word;
    end
    fd = $fopen("bilin_testdata.txt", "r");
    if (fd == 0) begin
      $display("Could not open bilin_testdata.txt for reading");
      stop_with_failure();
    end
    cycles = 2000;
    while (!$feof(fd)) begin
      line = '0;
      rc = $fgets(line, fd);
      // Comment and blank lines do not scan
      if (rc != 0 && $sscanf(line, "%d %d %h %d %d", a, b, c, d, e) == 5) begin
        q_in_w.push_back(a);
        q_in_h.push_back(b);
        q_scale.push_back(c);
        q_out_w.push_back(d);
        q_out_h.push_back(e);
        cycles = cycles + 40 * d * e;
      end
    end
    $fclose(fd);
    if (q_in_w.size() == 0) begin
      $display("No test lines found in bilin_testdata.txt");
      stop_with_failure();
    end
    wd_cycles = cycles;
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    check_eq(o_busy, 1'b0, "o_busy after reset");
    check_eq(o_done, 1'b0, "o_done after reset");
    check_eq(o_req_valid, 1'b0, "o_req_valid after reset");
    check_eq(o_out_we, 1'b0, "o_out_we after reset");
    for (int t = 0; t < q_in_w.size(); t++) begin
      run_scale(t);
    end
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

// File: bilin_scaler_top.f
bilin_fix_pkg.sv
bilin_seq_pkg.sv
bilin_scale_setup.sv
bilin_coord_gen.sv
bilin_neighbor_fetch.sv
bilin_interp.sv
bilin_scaler_top.sv
bilin_scaler_tb.sv

// File: Bender.yml
package:
  name: bilin_scaler

sources:
  - bilin_fix_pkg.sv
  - bilin_seq_pkg.sv
  - bilin_scale_setup.sv
  - bilin_coord_gen.sv
  - bilin_neighbor_fetch.sv
  - bilin_interp.sv
  - bilin_scaler_top.sv
  - target: test
    files:
      - bilin_scaler_tb.sv

// File: bilin_testdata.txt
# in_w in_h scale_q88(hex) exp_out_w exp_out_h
# one run per line, scale is Q8.8 (0100 = 1.0)
8 6 0200 16 12
16 8 0080 8 4
13 9 0180 19 13
64 4 0100 64 4
2 2 0300 6 6
10 7 00c0 7 5
20 20 0155 26 26
